// File: verilog/smpc_pkg.sv
package smpc_pkg;

	// Command byte; codes outside the list are still legal values
	typedef enum logic [7:0] {
		MSHON   = 8'h00,
		SSHON   = 8'h02,
		SSHOFF  = 8'h03,
		SNDON   = 8'h06,
		SNDOFF  = 8'h07,
		CDON    = 8'h08,
		CDOFF   = 8'h09,
		INTBACK = 8'h10,
		SETTIME = 8'h16,
		SETSMEM = 8'h17,
		NMIREQ  = 8'h18,
		RESENAB = 8'h19,
		RESDISA = 8'h1A
	} cmd_t;

	typedef struct packed {
		logic [3:0] hi;
		logic [3:0] lo;
	} bcd_t;

	typedef logic [4:0]      oreg_addr_t;
	typedef logic [3:0][7:0] ireg_t;   // IREG0 in [0]
	typedef logic [15:0]     wait_t;

	localparam wait_t WAIT_POWER   = 16'd120;
	localparam wait_t WAIT_CD      = 16'd159;
	localparam wait_t WAIT_INTBACK = 16'd500;
	localparam wait_t WAIT_SETTIME = 16'd279;
	localparam wait_t WAIT_MISC    = 16'd127;

	// Byte addresses on the host side, always odd
	localparam logic [6:0] ADDR_IREG0     = 7'h01;
	localparam logic [6:0] ADDR_IREG3     = 7'h07;
	localparam logic [6:0] ADDR_COMREG    = 7'h1F;
	localparam logic [6:0] ADDR_OREG_LAST = 7'h5F;
	localparam logic [6:0] ADDR_SR        = 7'h61;
	localparam logic [6:0] ADDR_SF        = 7'h63;

	localparam logic [7:0] STATUS_YEAR_HI = 8'h20;
	localparam logic [7:0] STATUS_YEAR_LO = 8'h22;
	localparam logic [7:0] STATUS_MONTH   = 8'h01;

	localparam oreg_addr_t OREG_CMD_SLOT = 5'd31;
	localparam logic [2:0] SR_INTBACK_DONE = 3'b010;
	localparam logic [7:0] INTBACK_IREG2_KEY = 8'hF0;

endpackage

// File: verilog/smpc_host_regs.sv
module smpc_host_regs (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic [5:0]             a,
	input  logic [7:0]             din,
	output logic [7:0]             dout,
	input  logic                   cs_n,
	input  logic                   rw_n,
	output smpc_pkg::cmd_t         comreg,
	output logic                   cmd_pending,
	input  logic                   cmd_ack,
	input  logic                   cmd_done,
	output smpc_pkg::ireg_t        ireg,
	input  logic [2:0]             sr_result,
	output smpc_pkg::oreg_addr_t   oreg_ra,
	input  logic [7:0]             oreg_q
);

	logic       rw_n_old;
	logic       cs_n_old;
	logic       pend;
	logic       sf;
	logic [6:0] byte_addr;
	logic [7:0] rd_data;
	logic       wr_strobe;
	logic       rd_strobe;

	assign byte_addr = {a, 1'b1};
	assign oreg_ra   = a[4:0] - 5'd16;   // OREG index is a minus 16

	assign wr_strobe = !rw_n && rw_n_old && !cs_n;
	assign rd_strobe = !cs_n && cs_n_old && rw_n;

	// Sequencer only starts once the host has raised SF
	assign cmd_pending = pend && sf;

	always_comb begin
		if (byte_addr <= smpc_pkg::ADDR_OREG_LAST)
			rd_data = oreg_q;
		else if (byte_addr == smpc_pkg::ADDR_SR)
			rd_data = {sr_result, 1'b0, ireg[1][7:4]};
		else if (byte_addr == smpc_pkg::ADDR_SF)
			rd_data = {7'b0000000, sf};
		else
			rd_data = 8'h00;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			comreg   <= smpc_pkg::MSHON;
			pend     <= 1'b0;
			sf       <= 1'b0;
			ireg     <= '0;
			dout     <= 8'h00;
		end else begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;
			if (cmd_ack)
				pend <= 1'b0;
			if (cmd_done && !pend)   // A queued command keeps SF busy
				sf <= 1'b0;
			if (wr_strobe) begin
				if (byte_addr >= smpc_pkg::ADDR_IREG0 && byte_addr <= smpc_pkg::ADDR_IREG3) begin
					ireg[a[1:0]] <= din;
				end else if (byte_addr == smpc_pkg::ADDR_COMREG) begin
					comreg <= smpc_pkg::cmd_t'(din);
					pend   <= 1'b1;
				end else if (byte_addr == smpc_pkg::ADDR_SF && din[0]) begin
					sf <= 1'b1;
				end
			end
			if (rd_strobe)
				dout <= rd_data;   // Held until next read
		end
	end

endmodule

// File: verilog/smpc_oreg_ram.sv
module smpc_oreg_ram (
	input  logic                 CLK,
	input  logic                 oreg_we,
	input  smpc_pkg::oreg_addr_t oreg_wa,
	input  logic [7:0]           oreg_wd,
	input  smpc_pkg::oreg_addr_t oreg_ra,
	output logic [7:0]           oreg_q
);

	// 32 x 8 output registers, written only by the sequencer
	logic [7:0] mem [32];

	always_ff @(posedge CLK) begin
		if (oreg_we)
			mem[oreg_wa] <= oreg_wd;
	end

	assign oreg_q = mem[oreg_ra];   // Async read

endmodule

// File: verilog/smpc_rtc.sv
module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic           CLK,
	input  logic           RST_N,
	output smpc_pkg::bcd_t sec,
	output smpc_pkg::bcd_t min,
	output smpc_pkg::bcd_t hour,
	output smpc_pkg::bcd_t day
);

	localparam int CNT_W = $clog2(TICKS_PER_SEC + 1);

	logic [CNT_W-1:0] div_cnt;
	logic             tick;

	function automatic smpc_pkg::bcd_t bcd_inc(input smpc_pkg::bcd_t v);
		smpc_pkg::bcd_t r;
		if (v.lo == 4'd9) begin
			r.hi = v.hi + 4'd1;
			r.lo = 4'd0;
		end else begin
			r.hi = v.hi;
			r.lo = v.lo + 4'd1;
		end
		return r;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (div_cnt == CNT_W'(TICKS_PER_SEC - 1)) begin
				div_cnt <= '0;
				tick    <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sec  <= 8'h00;
			min  <= 8'h00;
			hour <= 8'h00;
			day  <= 8'h01;
		end else if (tick) begin
			if (sec != 8'h59) begin
				sec <= bcd_inc(sec);
			end else begin
				sec <= 8'h00;
				if (min != 8'h59) begin
					min <= bcd_inc(min);
				end else begin
					min <= 8'h00;
					if (hour != 8'h23) begin
						hour <= bcd_inc(hour);
					end else begin
						hour <= 8'h00;
						day  <= (day == 8'h31) ? 8'h01 : bcd_inc(day);   // 01..31
					end
				end
			end
		end
	end

endmodule

// File: verilog/smpc_cmd_seq.sv
module smpc_cmd_seq (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  smpc_pkg::cmd_t       comreg,
	input  logic                 cmd_pending,
	output logic                 cmd_ack,
	output logic                 cmd_done,
	input  smpc_pkg::ireg_t      ireg,
	output logic [2:0]           sr_result,
	output logic                 oreg_we,
	output smpc_pkg::oreg_addr_t oreg_wa,
	output logic [7:0]           oreg_wd,
	input  smpc_pkg::bcd_t       sec,
	input  smpc_pkg::bcd_t       min,
	input  smpc_pkg::bcd_t       hour,
	input  smpc_pkg::bcd_t       day,
	input  logic [3:0]           ac,
	output logic                 mshres_n,
	output logic                 mshnmi_n,
	output logic                 sshres_n,
	output logic                 sshnmi_n,
	output logic                 sndres_n,
	output logic                 cdres_n,
	output logic                 mirq_n
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_WAIT,
		ST_EXEC,
		ST_END
	} state_t;

	state_t               state;
	smpc_pkg::cmd_t       cur_cmd;
	smpc_pkg::wait_t      wait_cnt;
	smpc_pkg::oreg_addr_t oreg_cnt;
	smpc_pkg::ireg_t      smem;      // Battery backed bytes
	logic                 resd;
	logic                 ste;
	logic                 intback_ok;

	assign cmd_ack  = (state == ST_IDLE) && cmd_pending;
	assign cmd_done = (state == ST_END);
	assign intback_ok = ireg[2] == smpc_pkg::INTBACK_IREG2_KEY && ireg[0][0];

	assign oreg_we = (state == ST_EXEC);
	assign oreg_wa = (cur_cmd == smpc_pkg::INTBACK) ? oreg_cnt : smpc_pkg::OREG_CMD_SLOT;

	// Status block for INTBACK, otherwise just the command echo
	always_comb begin
		oreg_wd = cur_cmd;
		if (cur_cmd == smpc_pkg::INTBACK) begin
			case (oreg_cnt)
				5'd0:    oreg_wd = {ste, resd, 6'b000000};
				5'd1:    oreg_wd = smpc_pkg::STATUS_YEAR_HI;
				5'd2:    oreg_wd = smpc_pkg::STATUS_YEAR_LO;
				5'd3:    oreg_wd = smpc_pkg::STATUS_MONTH;
				5'd4:    oreg_wd = day;
				5'd5:    oreg_wd = hour;
				5'd6:    oreg_wd = min;
				5'd7:    oreg_wd = sec;
				5'd9:    oreg_wd = {4'b0000, ac};
				5'd10:   oreg_wd = {4'b0011, ~mshnmi_n, 2'b10, ~sndres_n};   // No dot sel, SYSRES
				5'd11:   oreg_wd = {1'b0, ~cdres_n, 6'b000000};
				5'd12:   oreg_wd = smem[0];
				5'd13:   oreg_wd = smem[1];
				5'd14:   oreg_wd = smem[2];
				5'd15:   oreg_wd = smem[3];
				5'd31:   oreg_wd = cur_cmd;
				default: oreg_wd = 8'h00;
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= ST_IDLE;
			cur_cmd   <= smpc_pkg::MSHON;
			wait_cnt  <= '0;
			oreg_cnt  <= '0;
			smem      <= '0;
			resd      <= 1'b1;
			ste       <= 1'b0;
			sr_result <= 3'b000;
			mshres_n  <= 1'b0;
			mshnmi_n  <= 1'b0;
			sshres_n  <= 1'b0;
			sshnmi_n  <= 1'b0;
			sndres_n  <= 1'b0;
			cdres_n   <= 1'b0;
			mirq_n    <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_pending) begin
						cur_cmd <= comreg;
						state   <= ST_START;
					end
				end
				ST_START: begin
					oreg_cnt <= '0;
					state    <= ST_WAIT;
					case (cur_cmd)
						smpc_pkg::MSHON, smpc_pkg::SSHON, smpc_pkg::SSHOFF,
						smpc_pkg::SNDON, smpc_pkg::SNDOFF:
							wait_cnt <= smpc_pkg::WAIT_POWER;
						smpc_pkg::CDON, smpc_pkg::CDOFF, smpc_pkg::SETSMEM:
							wait_cnt <= smpc_pkg::WAIT_CD;
						smpc_pkg::SETTIME:
							wait_cnt <= smpc_pkg::WAIT_SETTIME;
						smpc_pkg::NMIREQ, smpc_pkg::RESENAB, smpc_pkg::RESDISA:
							wait_cnt <= smpc_pkg::WAIT_MISC;
						smpc_pkg::INTBACK: begin
							wait_cnt <= smpc_pkg::WAIT_INTBACK;
							if (!intback_ok)
								state <= ST_END;
						end
						default: state <= ST_EXEC;   // Unknown code, echo only
					endcase
				end
				ST_WAIT: begin
					wait_cnt <= wait_cnt - 1'b1;
					if (wait_cnt == smpc_pkg::wait_t'(1))
						state <= ST_EXEC;
				end
				ST_EXEC: begin
					state <= ST_END;
					case (cur_cmd)
						smpc_pkg::MSHON:   {mshres_n, mshnmi_n} <= 2'b11;
						smpc_pkg::SSHON:   {sshres_n, sshnmi_n} <= 2'b11;
						smpc_pkg::SSHOFF:  {sshres_n, sshnmi_n} <= 2'b01;
						smpc_pkg::SNDON:   sndres_n <= 1'b1;
						smpc_pkg::SNDOFF:  sndres_n <= 1'b0;
						smpc_pkg::CDON:    cdres_n <= 1'b1;
						smpc_pkg::CDOFF:   cdres_n <= 1'b0;
						smpc_pkg::NMIREQ:  mshnmi_n <= 1'b0;
						smpc_pkg::RESENAB: resd <= 1'b0;
						smpc_pkg::RESDISA: resd <= 1'b1;
						smpc_pkg::SETTIME: ste <= 1'b1;
						smpc_pkg::SETSMEM: smem <= ireg;
						smpc_pkg::INTBACK: begin
							// One status byte per cycle, 32 in all
							oreg_cnt <= oreg_cnt + 1'b1;
							if (oreg_cnt != 5'd31)
								state <= ST_EXEC;
							if (oreg_cnt == 5'd30) begin
								sr_result <= smpc_pkg::SR_INTBACK_DONE;
								mirq_n    <= 1'b0;
							end
						end
						default: ;
					endcase
				end
				ST_END: begin
					if (cur_cmd == smpc_pkg::NMIREQ)
						mshnmi_n <= 1'b1;
					mirq_n <= 1'b1;
					state  <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/smpc.sv
module smpc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [5:0] a,
	input  logic [7:0] din,
	output logic [7:0] dout,
	input  logic       cs_n,
	input  logic       rw_n,
	input  logic [3:0] ac,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);

	smpc_pkg::cmd_t       comreg;
	smpc_pkg::ireg_t      ireg;
	smpc_pkg::oreg_addr_t oreg_wa;
	smpc_pkg::oreg_addr_t oreg_ra;
	smpc_pkg::bcd_t       sec;
	smpc_pkg::bcd_t       min;
	smpc_pkg::bcd_t       hour;
	smpc_pkg::bcd_t       day;
	logic                 cmd_pending;
	logic                 cmd_ack;
	logic                 cmd_done;
	logic [2:0]           sr_result;
	logic                 oreg_we;
	logic [7:0]           oreg_wd;
	logic [7:0]           oreg_q;

	smpc_host_regs host_regs_inst (
		.CLK, .RST_N, .a, .din, .dout, .cs_n, .rw_n,
		.comreg, .cmd_pending, .cmd_ack, .cmd_done, .ireg,
		.sr_result, .oreg_ra, .oreg_q
	);

	smpc_oreg_ram oreg_ram_inst (
		.CLK, .oreg_we, .oreg_wa, .oreg_wd, .oreg_ra, .oreg_q
	);

	smpc_rtc #(.TICKS_PER_SEC(TICKS_PER_SEC)) rtc_inst (
		.CLK, .RST_N, .sec, .min, .hour, .day
	);

	smpc_cmd_seq cmd_seq_inst (
		.CLK, .RST_N, .comreg, .cmd_pending, .cmd_ack, .cmd_done, .ireg,
		.sr_result, .oreg_we, .oreg_wa, .oreg_wd, .sec, .min, .hour, .day, .ac,
		.mshres_n, .mshnmi_n, .sshres_n, .sshnmi_n, .sndres_n, .cdres_n, .mirq_n
	);

endmodule

// File: verification/smpc_assertions.sv
module smpc_assertions (
	input logic                 CLK,
	input logic                 RST_N,
	input logic                 oreg_we,
	input logic                 in_exec,
	input smpc_pkg::bcd_t       sec,
	input smpc_pkg::bcd_t       min,
	input smpc_pkg::bcd_t       hour,
	input smpc_pkg::bcd_t       day,
	input logic                 mirq_n,
	input logic [2:0]           sr_result
);

	function automatic bit digits_ok(input smpc_pkg::bcd_t v);
		return v.hi <= 4'd9 && v.lo <= 4'd9;
	endfunction

	we_in_exec: assert property (@(posedge CLK) disable iff (!RST_N) oreg_we |-> in_exec)
		else $error("oreg_we asserted outside exec");

	rtc_bcd: assert property (@(posedge CLK) disable iff (!RST_N)
		digits_ok(sec) && digits_ok(min) && digits_ok(hour) && digits_ok(day))
		else $error("RTC digit above 9");

	mirq_sr: assert property (@(posedge CLK) disable iff (!RST_N)
		!mirq_n |-> sr_result == smpc_pkg::SR_INTBACK_DONE)
		else $error("mirq_n low without INTBACK result in SR");

endmodule

bind smpc_cmd_seq smpc_assertions assertions_inst (
	.CLK, .RST_N, .oreg_we,
	.in_exec(state == ST_EXEC),
	.sec, .min, .hour, .day, .mirq_n, .sr_result
);

// File: verification/smpc_tb.sv
module smpc_tb;

	localparam int TICKS = 50;
	localparam int NROWS = 15;
	// Host word addresses, the byte address is 2a+1
	localparam logic [5:0] A_COMREG = 6'h0F;
	localparam logic [5:0] A_OREG0  = 6'h10;
	localparam logic [5:0] A_OREG31 = 6'h2F;
	localparam logic [5:0] A_SR     = 6'h30;
	localparam logic [5:0] A_SF     = 6'h31;

	typedef struct packed {
		smpc_pkg::cmd_t  cmd;
		smpc_pkg::ireg_t ireg;
		logic [5:0]      lines;    // mshres_n mshnmi_n sshres_n sshnmi_n sndres_n cdres_n
		smpc_pkg::cmd_t  oreg31;
		logic            intb;     // Valid INTBACK, status block checked
		logic [7:0]      b0;
		logic [7:0]      sr;
		smpc_pkg::wait_t wait_len;
	} row_t;

	logic       CLK, RST_N, cs_n, rw_n;
	logic [5:0] a;
	logic [7:0] din, dout;
	logic [3:0] ac;
	logic       mshres_n, mshnmi_n, sshres_n, sshnmi_n, sndres_n, cdres_n, mirq_n;
	row_t       tbl [NROWS];
	int         cycles = 0;
	int         limit = 0;
	int         mism = 0;
	int         fails = 0;
	int         mirq_low = 0;
	int         last_secs = -1;

	smpc #(.TICKS_PER_SEC(TICKS)) smpc_inst (
		.CLK, .RST_N, .a, .din, .dout, .cs_n, .rw_n, .ac,
		.mshres_n, .mshnmi_n, .sshres_n, .sshnmi_n, .sndres_n, .cdres_n, .mirq_n
	);

	always #20 CLK = ~CLK;

	always @(negedge CLK)
		if (!mirq_n)
			mirq_low <= mirq_low + 1;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("run stopped at the cycle limit of %0d", limit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mism++;
		end
	endtask

	task automatic check_cmd(input string name, input smpc_pkg::cmd_t got,
			input smpc_pkg::cmd_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mism++;
		end
	endtask

	task automatic check_bcd(input string name, input smpc_pkg::bcd_t got,
			input smpc_pkg::bcd_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mism++;
		end
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mism++;
		end
	endtask

	task automatic check_lines(input logic [5:0] exp);
		check_line("mshres_n", mshres_n, exp[5]);
		check_line("mshnmi_n", mshnmi_n, exp[4]);
		check_line("sshres_n", sshres_n, exp[3]);
		check_line("sshnmi_n", sshnmi_n, exp[2]);
		check_line("sndres_n", sndres_n, exp[1]);
		check_line("cdres_n", cdres_n, exp[0]);
	endtask

	function automatic bit bcd_valid(input smpc_pkg::bcd_t v);
		return v.hi <= 4'd9 && v.lo <= 4'd9;
	endfunction

	function automatic int bcd_value(input smpc_pkg::bcd_t v);
		return v.hi * 10 + v.lo;
	endfunction

	task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
		@(posedge CLK);
		#5;
		a    = addr;
		din  = data;
		cs_n = 1'b0;
		rw_n = 1'b0;
		@(posedge CLK);
		#5;
		cs_n = 1'b1;
		rw_n = 1'b1;
	endtask

	task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
		@(posedge CLK);
		#5;
		a    = addr;
		cs_n = 1'b0;
		rw_n = 1'b1;
		@(posedge CLK);   // Strobe taken here
		@(posedge CLK);
		#5;
		data = dout;
		cs_n = 1'b1;
	endtask

	task automatic run_cmd(input row_t r);
		logic [7:0] d;
		int         start;
		for (int i = 0; i < 4; i++)
			bus_write(6'(i), r.ireg[i]);
		bus_write(A_COMREG, r.cmd);
		bus_write(A_SF, 8'h01);
		start = cycles;
		bus_read(A_SF, d);
		while (d[0] && cycles - start < r.wait_len + 200)
			bus_read(A_SF, d);
		if (d[0]) begin
			$display("SF still set %0d cycles after command 0x%h", cycles - start, r.cmd);
			fails++;
		end
	endtask

	task automatic check_status(input row_t r, input smpc_pkg::ireg_t smem);
		logic [7:0] st [16];
		logic [7:0] d;
		int         secs;
		for (int k = 0; k < 16; k++)
			bus_read(A_OREG0 + 6'(k), st[k]);
		check_byte("status byte 0", st[0], r.b0);
		check_byte("year high", st[1], 8'h20);
		check_byte("year low", st[2], 8'h22);
		check_byte("month", st[3], 8'h01);
		check_bcd("day", st[4], 8'h01);
		check_bcd("hour", st[5], 8'h00);
		if (cycles < 60 * TICKS)   // Under a minute since reset
			check_bcd("min", st[6], 8'h00);
		if (!bcd_valid(st[7])) begin
			$display("seconds byte 0x%h is not valid BCD", st[7]);
			fails++;
		end
		secs = bcd_value(st[6]) * 60 + bcd_value(st[7]);
		if (secs <= last_secs) begin
			$display("clock did not advance between two INTBACK commands");
			fails++;
		end
		last_secs = secs;
		check_byte("status byte 8", st[8], 8'h00);
		check_byte("area code", st[9], {4'h0, ac});
		check_byte("status byte 10", st[10], {4'b0011, ~r.lines[4], 2'b10, ~r.lines[1]});
		check_byte("status byte 11", st[11], {1'b0, ~r.lines[0], 6'b000000});
		for (int k = 0; k < 4; k++)
			check_byte("battery memory", st[12 + k], smem[k]);
		bus_read(A_SR, d);
		check_byte("SR", d, r.sr);
	endtask

	initial begin : main
		logic [7:0]      d;
		smpc_pkg::ireg_t smem;
		int              snap;
		CLK   = 1'b0;
		RST_N = 1'b0;
		a     = '0;
		din   = '0;
		cs_n  = 1'b1;
		rw_n  = 1'b1;
		ac    = 4'h5;
		smem  = '0;
		// cmd, ireg3..0, lines, oreg31, status, byte0, sr, wait
		tbl[0]  = {8'h00, 32'h0, 6'b110000, 8'h00, 1'b0, 8'h00, 8'h00, 16'd120};
		tbl[1]  = {8'h02, 32'h0, 6'b111100, 8'h02, 1'b0, 8'h00, 8'h00, 16'd120};
		tbl[2]  = {8'h06, 32'h0, 6'b111110, 8'h06, 1'b0, 8'h00, 8'h00, 16'd120};
		tbl[3]  = {8'h08, 32'h0, 6'b111111, 8'h08, 1'b0, 8'h00, 8'h00, 16'd159};
		tbl[4]  = {8'h03, 32'h0, 6'b110111, 8'h03, 1'b0, 8'h00, 8'h00, 16'd120};
		tbl[5]  = {8'h07, 32'h0, 6'b110101, 8'h07, 1'b0, 8'h00, 8'h00, 16'd120};
		tbl[6]  = {8'h09, 32'h0, 6'b110100, 8'h09, 1'b0, 8'h00, 8'h00, 16'd159};
		tbl[7]  = {8'h18, 32'h0, 6'b110100, 8'h18, 1'b0, 8'h00, 8'h00, 16'd127};
		tbl[8]  = {8'h1F, 32'h0, 6'b110100, 8'h1F, 1'b0, 8'h00, 8'h00, 16'd0};
		tbl[9]  = {8'h19, 32'h0, 6'b110100, 8'h19, 1'b0, 8'h00, 8'h00, 16'd127};
		tbl[10] = {8'h16, 32'h0, 6'b110100, 8'h16, 1'b0, 8'h00, 8'h00, 16'd279};
		tbl[11] = {8'h17, 32'h44332211, 6'b110100, 8'h17, 1'b0, 8'h00, 8'h00, 16'd159};
		tbl[12] = {8'h10, 32'h0000A001, 6'b110100, 8'h17, 1'b0, 8'h00, 8'h00, 16'd0};
		tbl[13] = {8'h10, 32'h00F0A001, 6'b110100, 8'h10, 1'b1, 8'h80, 8'h4A, 16'd500};
		tbl[14] = {8'h10, 32'h00F0A001, 6'b110100, 8'h10, 1'b1, 8'h80, 8'h4A, 16'd500};
		for (int i = 0; i < NROWS; i++)
			limit += tbl[i].wait_len;
		limit = 2 * (limit + 40 * NROWS);
		repeat (3) @(posedge CLK);
		#5 RST_N = 1'b1;
		check_lines(6'b000000);
		check_line("mirq_n", mirq_n, 1'b1);
		bus_read(A_SF, d);
		check_byte("SF", d, 8'h00);
		bus_read(A_SR, d);
		check_byte("SR", d, 8'h00);
		for (int i = 0; i < NROWS; i++) begin
			snap = mirq_low;
			run_cmd(tbl[i]);
			check_lines(tbl[i].lines);
			bus_read(A_OREG31, d);
			check_cmd("OREG31", smpc_pkg::cmd_t'(d), tbl[i].oreg31);
			check_byte("mirq_n low cycles", 8'(mirq_low - snap), tbl[i].intb ? 8'd2 : 8'd0);
			if (tbl[i].cmd == smpc_pkg::SETSMEM)
				smem = tbl[i].ireg;
			if (tbl[i].intb)
				check_status(tbl[i], smem);
		end
		$display("%0d mismatches, %0d other errors, cycle limit %0d", mism, fails, limit);
		if (mism == 0 && fails == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verilog.f
verilog/smpc_pkg.sv
verilog/smpc_host_regs.sv
verilog/smpc_oreg_ram.sv
verilog/smpc_rtc.sv
verilog/smpc_cmd_seq.sv
verilog/smpc.sv
verification/smpc_assertions.sv
verification/smpc_tb.sv

// File: Bender.yml
package:
  name: smpc

sources:
  - files:
      - verilog/smpc_pkg.sv
      - verilog/smpc_host_regs.sv
      - verilog/smpc_oreg_ram.sv
      - verilog/smpc_rtc.sv
      - verilog/smpc_cmd_seq.sv
      - verilog/smpc.sv
  - target: test
    files:
      - verification/smpc_assertions.sv
      - verification/smpc_tb.sv
